/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* rv_core.f */
+incdir+.
rv_core_pkg.sv
rv_pipeline_ctrl.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_dmem.sv
rv_core.sv
tb_rv_core.sv

/* rv_core.sv */
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_core (
    input  logic                     clk,
    input  logic                     reset,
    input  rv_core_pkg::prog_write_t i_prog,
    input  logic                     i_start,
    output logic                     o_uart_valid,
    output logic [7:0]               o_uart_data,
    output logic                     o_running,
    output logic                     o_halted
);

    import rv_core_pkg::*;

    logic                imem_we;
    logic                run;
    logic                flush;
    logic                restart;
    logic                jump_taken;
    logic                ebreak;
    logic [`RV_XLEN-1:0] jump_target;
    logic [`RV_XLEN-1:0] load_data;
    fetch_t              fetch;
    decoded_t            dec;
    wb_t                 wb;
    mem_req_t            mem_req;

    rv_pipeline_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .i_prog       (i_prog),
        .i_jump_taken (jump_taken),
        .i_ebreak     (ebreak),
        .o_imem_we    (imem_we),
        .o_run        (run),
        .o_flush      (flush),
        .o_restart    (restart),
        .o_running    (o_running),
        .o_halted     (o_halted)
    );

    rv_fetch u_fetch (
        .clk           (clk),
        .reset         (reset),
        .i_run         (run),
        .i_flush       (flush),
        .i_restart     (restart),
        .i_imem_we     (imem_we),
        .i_prog        (i_prog),
        .i_jump_taken  (jump_taken),
        .i_jump_target (jump_target),
        .o_fetch       (fetch)
    );

    rv_decode u_decode (
        .clk     (clk),
        .reset   (reset),
        .i_run   (run),
        .i_flush (flush),
        .i_fetch (fetch),
        .i_wb    (wb),
        .o_dec   (dec)
    );

    rv_execute u_execute (
        .i_dec         (dec),
        .i_load_data   (load_data),
        .o_wb          (wb),
        .o_mem         (mem_req),
        .o_jump_taken  (jump_taken),
        .o_jump_target (jump_target),
        .o_ebreak      (ebreak)
    );

    rv_dmem u_dmem (
        .clk          (clk),
        .i_mem        (mem_req),
        .o_load_data  (load_data),
        .o_uart_valid (o_uart_valid),
        .o_uart_data  (o_uart_data)
    );

endmodule

/* rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`define RV_XLEN          32
`define RV_REG_ADDR_W    5

`define RV_IMEM_ADDR_W   8
`define RV_IMEM_DEPTH    256
`define RV_DMEM_ADDR_W   8
`define RV_DMEM_DEPTH    256

// stores here go to the uart, not to memory
`define RV_UART_TX_ADDR  32'h0002_0020

`define RV_NOP_INST      32'h0000_0013

`endif

/* rv_core_pkg.sv */
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_run,
        ctrl_halt
    } ctrl_state_e;

    typedef struct packed {
        logic                       valid;
        logic [`RV_IMEM_ADDR_W-1:0] addr;   // word address
        logic [`RV_XLEN-1:0]        data;
    } prog_write_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] inst;
        logic [`RV_XLEN-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        opcode_e                   opcode;
        alu_op_e                   alu_op;
        logic [2:0]                funct3;      // branch condition
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       op_a;        // rs1, or pc for auipc
        logic [`RV_XLEN-1:0]       rs2_val;
        logic [`RV_XLEN-1:0]       imm;
        logic [`RV_XLEN-1:0]       pc;
        logic                      writes_rd;
        logic                      is_ebreak;
    } decoded_t;

    typedef struct packed {
        logic                      valid;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                load;
        logic                store;
        logic [`RV_XLEN-1:0] addr;          // byte address
        logic [`RV_XLEN-1:0] data;
    } mem_req_t;

endpackage

/* rv_decode.sv */
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_run,
    input  logic                  i_flush,
    input  rv_core_pkg::fetch_t   i_fetch,
    input  rv_core_pkg::wb_t      i_wb,
    output rv_core_pkg::decoded_t o_dec
);

    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0]       regs [1:31];   // x0 is not stored
    logic [`RV_XLEN-1:0]       inst;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    opcode_e                   opcode;
    logic [`RV_XLEN-1:0]       imm_i;
    logic [`RV_XLEN-1:0]       imm_s;
    logic [`RV_XLEN-1:0]       imm_b;
    logic [`RV_XLEN-1:0]       imm_u;
    logic [`RV_XLEN-1:0]       imm_j;
    alu_op_e                   arith_op;
    logic                      arith_ok;
    logic                      known;
    decoded_t                  dec_next;

    // register read with bypass from the execute stage
    function automatic logic [`RV_XLEN-1:0] read_reg(input logic [`RV_REG_ADDR_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (i_wb.valid && (i_wb.rd == idx)) begin
            return i_wb.data;
        end
        return regs[idx];
    endfunction

    assign inst   = i_fetch.inst;
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign opcode = opcode_e'(inst[6:0]);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
        // funct7 only matters for shifts, and for every register form
        if (funct3 == 3'b001) begin
            arith_ok = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
            arith_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else if (opcode == opc_op) begin
            arith_ok = (funct7 == 7'b0000000) || (funct3 == 3'b000 && funct7 == 7'b0100000);
        end else begin
            arith_ok = 1'b1;
        end
    end

    always_comb begin
        dec_next           = '0;
        dec_next.opcode    = opcode;
        dec_next.alu_op    = alu_add;
        dec_next.funct3    = funct3;
        dec_next.rd        = inst[11:7];
        dec_next.op_a      = read_reg(rs1);
        dec_next.rs2_val   = read_reg(rs2);
        dec_next.imm       = imm_i;
        dec_next.pc        = i_fetch.pc;
        dec_next.writes_rd = 1'b0;
        dec_next.is_ebreak = 1'b0;
        known              = 1'b1;
        case (opcode)
            opc_lui: begin
                dec_next.alu_op    = alu_pass_b;
                dec_next.imm       = imm_u;
                dec_next.writes_rd = 1'b1;
            end
            opc_auipc: begin
                dec_next.op_a      = i_fetch.pc;
                dec_next.imm       = imm_u;
                dec_next.writes_rd = 1'b1;
            end
            opc_jal: begin
                dec_next.imm       = imm_j;
                dec_next.writes_rd = 1'b1;
            end
            opc_jalr: begin
                known              = (funct3 == 3'b000);
                dec_next.writes_rd = 1'b1;
            end
            opc_branch: begin
                dec_next.imm = imm_b;
                known        = (funct3[2:1] != 2'b01);
            end
            opc_load: begin
                known              = (funct3 == 3'b010);   // lw only
                dec_next.writes_rd = 1'b1;
            end
            opc_store: begin
                dec_next.imm = imm_s;
                known        = (funct3 == 3'b010);         // sw only
            end
            opc_op_imm, opc_op: begin
                dec_next.alu_op    = arith_op;
                dec_next.writes_rd = 1'b1;
                known              = arith_ok;
            end
            opc_system: begin
                dec_next.is_ebreak = (inst == 32'h0010_0073);
                known              = dec_next.is_ebreak;
            end
            default: known = 1'b0;
        endcase
        dec_next.valid = i_fetch.valid && known;   // unknown words become bubbles
    end

    always_ff @(posedge clk) begin
        if (i_wb.valid) begin
            regs[i_wb.rd] <= i_wb.data;   // rd is never 0 here
        end
    end

    always_ff @(posedge clk) begin
        if (i_run) begin
            o_dec <= dec_next;
        end
        if (reset || i_flush) begin
            o_dec.valid <= 1'b0;
        end
    end

endmodule

/* rv_dmem.sv */
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_dmem (
    input  logic                  clk,
    input  rv_core_pkg::mem_req_t i_mem,
    output logic [`RV_XLEN-1:0]   o_load_data,
    output logic                  o_uart_valid,
    output logic [7:0]            o_uart_data
);

    logic [`RV_XLEN-1:0]        mem [0:`RV_DMEM_DEPTH-1];
    logic [`RV_DMEM_ADDR_W-1:0] word_addr;
    logic                       to_uart;

    assign word_addr = i_mem.addr[`RV_DMEM_ADDR_W+1:2];   // upper bits alias
    assign to_uart   = (i_mem.addr == `RV_UART_TX_ADDR);

    assign o_load_data  = i_mem.load ? mem[word_addr] : '0;
    assign o_uart_valid = i_mem.store && to_uart;
    assign o_uart_data  = i_mem.data[7:0];

    always_ff @(posedge clk) begin
        if (i_mem.store && !to_uart) begin
            mem[word_addr] <= i_mem.data;
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_execute (
    input  rv_core_pkg::decoded_t i_dec,
    input  logic [`RV_XLEN-1:0]   i_load_data,
    output rv_core_pkg::wb_t      o_wb,
    output rv_core_pkg::mem_req_t o_mem,
    output logic                  o_jump_taken,
    output logic [`RV_XLEN-1:0]   o_jump_target,
    output logic                  o_ebreak
);

    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] link;
    logic [`RV_XLEN-1:0] target_sum;
    logic                is_jal;
    logic                is_jalr;
    logic                br_cond;

    assign op_a  = i_dec.op_a;
    assign op_b  = (i_dec.opcode == opc_op) ? i_dec.rs2_val : i_dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_dec.alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sll:  alu_res = op_a << shamt;
            alu_slt:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_res = op_a ^ op_b;
            alu_srl:  alu_res = op_a >> shamt;
            alu_sra:  alu_res = $signed(op_a) >>> shamt;
            alu_or:   alu_res = op_a | op_b;
            alu_and:  alu_res = op_a & op_b;
            default:  alu_res = op_b;   // lui
        endcase
    end

    always_comb begin
        case (i_dec.funct3)
            3'b000:  br_cond = (op_a == i_dec.rs2_val);
            3'b001:  br_cond = (op_a != i_dec.rs2_val);
            3'b100:  br_cond = ($signed(op_a) < $signed(i_dec.rs2_val));
            3'b101:  br_cond = ($signed(op_a) >= $signed(i_dec.rs2_val));
            3'b110:  br_cond = (op_a < i_dec.rs2_val);
            3'b111:  br_cond = (op_a >= i_dec.rs2_val);
            default: br_cond = 1'b0;
        endcase
    end

    assign is_jal  = (i_dec.opcode == opc_jal);
    assign is_jalr = (i_dec.opcode == opc_jalr);
    assign link    = i_dec.pc + `RV_XLEN'd4;

    // one adder for branch, jal and jalr targets
    assign target_sum    = (is_jalr ? op_a : i_dec.pc) + i_dec.imm;
    assign o_jump_target = {target_sum[`RV_XLEN-1:1], 1'b0};
    assign o_jump_taken  = i_dec.valid &&
                           (is_jal || is_jalr || (i_dec.opcode == opc_branch && br_cond));
    assign o_ebreak      = i_dec.valid && i_dec.is_ebreak;

    assign o_mem.load  = i_dec.valid && (i_dec.opcode == opc_load);
    assign o_mem.store = i_dec.valid && (i_dec.opcode == opc_store);
    assign o_mem.addr  = alu_res;
    assign o_mem.data  = i_dec.rs2_val;

    assign o_wb.valid = i_dec.valid && i_dec.writes_rd && (i_dec.rd != '0);
    assign o_wb.rd    = i_dec.rd;
    assign o_wb.data  = o_mem.load ? i_load_data : ((is_jal || is_jalr) ? link : alu_res);

endmodule

/* rv_fetch.sv */
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_run,
    input  logic                     i_flush,
    input  logic                     i_restart,
    input  logic                     i_imem_we,
    input  rv_core_pkg::prog_write_t i_prog,
    input  logic                     i_jump_taken,
    input  logic [`RV_XLEN-1:0]      i_jump_target,
    output rv_core_pkg::fetch_t      o_fetch
);

    logic [`RV_XLEN-1:0] imem [0:`RV_IMEM_DEPTH-1];
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;

    always_comb begin
        if (i_restart) begin
            pc_next = '0;
        end else if (i_jump_taken) begin
            pc_next = i_jump_target;
        end else begin
            pc_next = pc + `RV_XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (i_restart || i_run) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_imem_we) begin
            imem[i_prog.addr] <= i_prog.data;   // load port only writes while idle or halted
        end
    end

    // synchronous read doubles as the fetch/decode register
    always_ff @(posedge clk) begin
        if (i_flush) begin
            o_fetch.inst <= `RV_NOP_INST;
        end else if (i_run) begin
            o_fetch.inst <= imem[pc[`RV_IMEM_ADDR_W+1:2]];
            o_fetch.pc   <= pc;
        end
        if (reset || i_flush) begin
            o_fetch.valid <= 1'b0;
        end else if (i_run) begin
            o_fetch.valid <= 1'b1;
        end
    end

endmodule

/* rv_pipeline_ctrl.sv */
`timescale 1ns/10ps

module rv_pipeline_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_start,
    input  rv_core_pkg::prog_write_t i_prog,
    input  logic                     i_jump_taken,
    input  logic                     i_ebreak,
    output logic                     o_imem_we,
    output logic                     o_run,
    output logic                     o_flush,
    output logic                     o_restart,
    output logic                     o_running,
    output logic                     o_halted
);

    import rv_core_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            ctrl_run: begin
                if (i_ebreak && !i_start) begin
                    state_next = ctrl_halt;
                end
            end
            default: begin   // idle or halted
                if (i_start) begin
                    state_next = ctrl_run;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrl_idle;
        end else begin
            state <= state_next;
        end
    end

    assign o_run     = (state == ctrl_run);
    assign o_flush   = i_start || (o_run && (i_jump_taken || i_ebreak));
    assign o_restart = i_start;                          // pc back to 0
    assign o_imem_we = i_prog.valid && !o_run;           // no writes under a live program
    assign o_running = o_run;
    assign o_halted  = (state == ctrl_halt);

endmodule

/* tb_rv_core.sv */
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module tb_rv_core;

    import rv_core_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    logic        clk;
    logic        reset;
    logic        i_start;
    prog_write_t i_prog;
    logic        o_uart_valid;
    logic [7:0]  o_uart_data;
    logic        o_running;
    logic        o_halted;

    logic [31:0] prog [0:`RV_IMEM_DEPTH-1];
    logic [31:0] ref_regs [0:31];
    logic [31:0] ref_dmem [0:`RV_DMEM_DEPTH-1];
    byte_q_t     exp_q;
    byte_q_t     got_q;
    int          n_words;
    int          mismatches;
    int          other_errors;
    logic        timed_out;

    rv_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .i_prog       (i_prog),
        .i_start      (i_start),
        .o_uart_valid (o_uart_valid),
        .o_uart_data  (o_uart_data),
        .o_running    (o_running),
        .o_halted     (o_halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction
    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction
    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction
    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction
    function automatic logic [31:0] enc_u(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction
    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic void add_word(input logic [31:0] w);
        prog[n_words] = w;
        n_words++;
    endfunction

    function automatic int pick_reg();
        return 1 + ($urandom % 7);
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA-level interpreter that collects the bytes sent to the uart
    function automatic byte_q_t rv_ref_run(input int limit);
        byte_q_t     q;
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic        wr;
        logic        take;
        logic        done;
        int          steps;
        pc = 0;
        done = 1'b0;
        for (steps = 0; steps < limit && !done; steps++) begin
            inst  = prog[pc[9:2]];
            a     = ref_regs[inst[19:15]];
            b     = ref_regs[inst[24:20]];
            f3    = inst[14:12];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            imm_u = {inst[31:12], 12'h000};
            imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            npc   = pc + 4;
            wr    = 1'b1;
            res   = '0;
            case (inst[6:0])
                7'h37: res = imm_u;
                7'h17: res = pc + imm_u;
                7'h6f: begin
                    res = pc + 4;
                    npc = pc + imm_j;
                end
                7'h67: begin
                    res = pc + 4;
                    npc = (a + imm_i) & ~32'd1;
                end
                7'h63: begin
                    wr = 1'b0;
                    case (f3)
                        3'd0: take = (a == b);
                        3'd1: take = (a != b);
                        3'd4: take = ($signed(a) < $signed(b));
                        3'd5: take = ($signed(a) >= $signed(b));
                        3'd6: take = (a < b);
                        default: take = (a >= b);
                    endcase
                    if (take) npc = pc + imm_b;
                end
                7'h03: res = ref_dmem[(a + imm_i) >> 2 & 32'hff];
                7'h23: begin
                    wr = 1'b0;
                    addr = a + imm_s;
                    if (addr == `RV_UART_TX_ADDR) q.push_back(b[7:0]);
                    else ref_dmem[addr[9:2]] = b;
                end
                7'h13: res = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);
                7'h33: res = alu_ref(f3, inst[30], a, b);
                default: begin   // ebreak ends the run
                    wr = 1'b0;
                    done = 1'b1;
                end
            endcase
            if (wr && inst[11:7] != 0) ref_regs[inst[11:7]] = res;
            pc = npc;
        end
        if (!done) begin
            other_errors++;
            $display("reference model did not reach ebreak");
        end
        return q;
    endfunction

    task automatic build_program();
        int kind;
        int rd;
        int f3;
        int f7;
        int imm;
        int k;
        int off;
        n_words = 0;
        for (int r = 1; r <= 7; r++) add_word(enc_i($urandom % 4096, 0, 0, r, 7'h13));
        add_word(enc_u(32'h20, 8, 7'h37));                 // x8 = uart address
        add_word(enc_i(32'h20, 8, 0, 8, 7'h13));
        for (int i = 0; i < 14; i++) begin
            kind = $urandom % 4;
            rd = pick_reg();
            f3 = $urandom % 8;
            if (kind == 0) begin
                f7 = ((f3 == 0 || f3 == 5) && ($urandom % 2)) ? 32 : 0;
                add_word(enc_r(f7, pick_reg(), pick_reg(), f3, rd));
            end else if (kind == 1) begin
                imm = (f3 == 1 || f3 == 5) ? ($urandom % 32) : ($urandom % 4096);
                if (f3 == 5 && ($urandom % 2)) imm = imm | 1024;
                add_word(enc_i(imm, pick_reg(), f3, rd, 7'h13));
            end else begin
                add_word(enc_u($urandom, rd, kind == 2 ? 7'h37 : 7'h17));
            end
            add_word(enc_s(0, rd, 8));                     // dependent store needs forwarding
        end
        for (int i = 0; i < 3; i++) begin
            off = ($urandom % 256) * 4;
            rd = pick_reg();
            add_word(enc_s(off, pick_reg(), 0));
            add_word(enc_i(off, 0, 2, rd, 7'h03));
            add_word(enc_s(0, rd, 8));
        end
        for (int i = 0; i < 9; i++) begin
            k = 1 + ($urandom % 3);
            kind = $urandom % 8;
            if (kind < 6) begin
                f3 = (kind < 2) ? kind : kind + 2;
                add_word(enc_b(4 * (k + 1), pick_reg(), pick_reg(), f3));
            end else if (kind == 6) begin
                add_word(enc_j(4 * (k + 1), 10));
            end else begin
                add_word(enc_u(0, 9, 7'h17));              // auipc x9, 0
                add_word(enc_i(8 + 4 * k, 9, 0, 10, 7'h67));
            end
            for (int s = 0; s < k; s++) add_word(enc_s(0, pick_reg(), 8));
            add_word(enc_s(0, kind >= 6 ? 10 : pick_reg(), 8));
        end
        add_word(32'h0010_0073);
    endtask

    task automatic load_program();
        for (int i = 0; i < n_words; i++) begin
            @(posedge clk);
            i_prog.valid <= 1'b1;
            i_prog.addr  <= i[7:0];
            i_prog.data  <= prog[i];
        end
        @(posedge clk);
        i_prog.valid <= 1'b0;
    endtask

    task automatic wait_for(input string what, input int limit, input logic want_halt);
        int   cnt;
        logic seen;
        cnt = 0;
        seen = 1'b0;
        do begin
            @(negedge clk);
            cnt++;
            seen = want_halt ? o_halted : o_running;
        end while (!seen && cnt < limit);
        if (!seen) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout while waiting for %s", what);
        end
    endtask

    task automatic run_program();
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        wait_for("core to run", 20, 1'b0);
        if (timed_out) return;
        @(posedge clk);                                    // must be ignored while running
        i_prog.valid <= 1'b1;
        i_prog.addr  <= 8'd12;
        i_prog.data  <= 32'h0010_0073;
        @(posedge clk);
        i_prog.valid <= 1'b0;
        wait_for("halt", 5000, 1'b1);
        if (timed_out) return;
        check_value("o_running after halt", o_running, 0);
        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected UART bytes never arrived", exp_q.size());
        end
    endtask

    always @(negedge clk) begin
        if (!reset && o_uart_valid) begin
            if (o_halted) begin
                other_errors++;
                $display("UART byte seen while halted");
            end
            got_q.push_back(o_uart_data);
        end
    end

    always @(posedge clk) begin
        while (got_q.size() > 0) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("unexpected UART byte %h", got_q.pop_front());
            end else begin
                check_value("uart byte", got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(13249));
        reset = 1'b1;
        i_start = 1'b0;
        i_prog = '0;
        mismatches = 0;
        other_errors = 0;
        timed_out = 1'b0;
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_value("idle outputs", {o_running, o_halted, o_uart_valid}, 0);
        end
        for (int p = 0; p < 2 && !timed_out; p++) begin
            build_program();
            load_program();
            exp_q = rv_ref_run(4000);
            run_program();
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
